// ==== filelist.f ====
rtl/mcic_pkg.sv
rtl/mcic_line_cache.sv
rtl/mcic_bus_read.sv
rtl/mcic_ctrl.sv
rtl/mcic_top.sv
test/mcic_mem_model.sv
test/mcic_tb.sv

// ==== rtl/mcic_bus_read.sv ====
`default_nettype none

module mcic_bus_read
  import mcic_pkg::*;
#(
  parameter logic [4:0] AR_ID = 5'h0a
)
(
  input  wire            mcic_clk,
  input  wire            cpurst_b,
  input  wire            miss_valid,
  input  wire mcic_pa_u  miss_addr,
  output logic           miss_ready,
  output logic           ar_valid,
  input  wire            ar_ready,
  output logic [4:0]     ar_id,
  output logic [39:0]    ar_addr,
  input  wire            r_valid,
  input  wire  [4:0]     r_id,
  input  wire  [127:0]   r_data,
  input  wire  [1:0]     r_resp,
  input  wire            r_ecc_err,
  output logic           fill_valid,
  input  wire            fill_ready,
  output logic [63:0]    fill_data,
  output logic           fill_err,
  output logic           refill_valid,
  output mcic_pa_u       refill_addr,
  output logic [127:0]   refill_line
);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_addr = 2'd1;
  localparam logic [1:0] st_wait = 2'd2;

  logic [1:0]  state_q;
  logic        id_vld_q;
  mcic_pa_u    addr_q;
  logic        r_id_hit;
  logic        resp_ok;
  logic        beat_clean;
  logic [63:0] beat_dword;
  logic        fill_done;

  // ==========================================================================
  // address channel
  // ==========================================================================
  assign miss_ready = (state_q == st_idle);
  assign ar_valid   = (state_q == st_addr);
  assign ar_id      = AR_ID;
  // always a whole-line read
  assign ar_addr    = {addr_q.bus.line_addr, 4'b0000};

  // ==========================================================================
  // data channel
  // ==========================================================================
  // only our own outstanding id completes; stray beats fall through
  assign r_id_hit   = r_valid && id_vld_q && (r_id == AR_ID);

  always_comb
  begin
    case (r_resp)
      mcic_resp_okay, mcic_resp_exokay:   resp_ok = 1'b1;
      mcic_resp_slverr, mcic_resp_decerr: resp_ok = 1'b0;
      default:                            resp_ok = 1'b0;
    endcase
  end

  assign beat_clean  = resp_ok && !r_ecc_err;
  // upper half for pa[3] set
  assign beat_dword  = addr_q.bus.line_off[3] ? r_data[127:64] : r_data[63:0];
  assign fill_done   = fill_valid && fill_ready;
  assign refill_addr = addr_q;

  // idle -> addr -> wait, back to idle once the fill is taken
  always_ff @(posedge mcic_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state_q <= st_idle;
    else
    begin
      case (state_q)
        st_idle:
          if (miss_valid)
            state_q <= st_addr;
        st_addr:
          if (ar_ready)
            state_q <= st_wait;
        st_wait:
          if (fill_done)
            state_q <= st_idle;
        default:
          state_q <= st_idle;
      endcase
    end
  end

  // id in flight, from ar handshake to matching beat
  always_ff @(posedge mcic_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      id_vld_q <= 1'b0;
    else if (r_id_hit)
      id_vld_q <= 1'b0;
    else if (ar_valid && ar_ready)
      id_vld_q <= 1'b1;
  end

  // fill handshake and refill pulse
  always_ff @(posedge mcic_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      fill_valid   <= 1'b0;
      refill_valid <= 1'b0;
    end
    else
    begin
      if (r_id_hit)
        fill_valid <= 1'b1;
      else if (fill_done)
        fill_valid <= 1'b0;
      // bad beats never reach the cache
      refill_valid <= r_id_hit && beat_clean;
    end
  end

  // payload
  always_ff @(posedge mcic_clk)
  begin
    if (miss_valid && miss_ready)
      addr_q <= miss_addr;
    if (r_id_hit)
    begin
      // zero data on ecc error
      fill_data <= r_ecc_err ? 64'd0 : beat_dword;
      fill_err  <= !beat_clean;
    end
    if (r_id_hit && beat_clean)
      refill_line <= r_data;
  end

  // ==========================================================================
  // checks
  // ==========================================================================
  a_ar_hold: assert property (
    @(posedge mcic_clk) disable iff (!cpurst_b)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr) && $stable(ar_id));

  a_no_fill_idle: assert property (
    @(posedge mcic_clk) disable iff (!cpurst_b)
    !(fill_valid && (state_q == st_idle)));

endmodule

`default_nettype wire

// ==== rtl/mcic_ctrl.sv ====
`default_nettype none

module mcic_ctrl
  import mcic_pkg::*;
(
  input  wire           mcic_clk,
  input  wire           cpurst_b,
  input  wire           req_valid,
  input  wire  [39:0]   req_addr,
  output logic          req_ready,
  output logic          resp_valid,
  output logic [63:0]   resp_data,
  output logic          resp_err,
  input  wire           resp_ready,
  output logic          lookup_valid,
  output mcic_pa_u      lookup_addr,
  input  wire           lookup_done,
  input  wire           lookup_hit,
  input  wire  [63:0]   lookup_data,
  output logic          miss_valid,
  output mcic_pa_u      miss_addr,
  input  wire           miss_ready,
  input  wire           fill_valid,
  output logic          fill_ready,
  input  wire  [63:0]   fill_data,
  input  wire           fill_err
);

  // request phases
  localparam logic [2:0] ph_idle = 3'd0;
  localparam logic [2:0] ph_look = 3'd1;
  localparam logic [2:0] ph_miss = 3'd2;
  localparam logic [2:0] ph_fill = 3'd3;
  localparam logic [2:0] ph_resp = 3'd4;

  logic        frz_q;
  logic [2:0]  phase_q;
  mcic_pa_u    addr_q;
  logic        req_acc;
  logic        resp_acc;
  logic        hit_done;
  logic        fill_acc;

  // ==========================================================================
  // handshakes
  // ==========================================================================
  // frozen from accept until the response is taken
  assign req_ready   = !frz_q;
  assign req_acc     = req_valid && req_ready;
  assign resp_valid  = (phase_q == ph_resp);
  assign resp_acc    = resp_valid && resp_ready;
  assign hit_done    = (phase_q == ph_look) && lookup_done && lookup_hit;
  assign miss_valid  = (phase_q == ph_miss);
  assign fill_ready  = (phase_q == ph_fill);
  assign fill_acc    = fill_valid && fill_ready;
  assign lookup_addr = addr_q;
  assign miss_addr   = addr_q;

  always_ff @(posedge mcic_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      frz_q <= 1'b0;
    else if (resp_acc)
      frz_q <= 1'b0;
    else if (req_acc)
      frz_q <= 1'b1;
  end

  // ==========================================================================
  // dispatch
  // ==========================================================================
  always_ff @(posedge mcic_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      phase_q      <= ph_idle;
      lookup_valid <= 1'b0;
    end
    else
    begin
      // single-cycle lookup pulse right after accept
      lookup_valid <= req_acc;
      case (phase_q)
        ph_idle:
          if (req_acc)
            phase_q <= ph_look;
        ph_look:
          if (lookup_done)
            phase_q <= lookup_hit ? ph_resp : ph_miss;
        ph_miss:
          if (miss_ready)
            phase_q <= ph_fill;
        ph_fill:
          if (fill_valid)
            phase_q <= ph_resp;
        ph_resp:
          if (resp_ready)
            phase_q <= ph_idle;
        default:
          phase_q <= ph_idle;
      endcase
    end
  end

  // ==========================================================================
  // response register
  // ==========================================================================
  always_ff @(posedge mcic_clk)
  begin
    if (req_acc)
      addr_q <= req_addr;
    // hit data is always clean
    if (hit_done)
    begin
      resp_data <= lookup_data;
      resp_err  <= 1'b0;
    end
    else if (fill_acc)
    begin
      resp_data <= fill_data;
      resp_err  <= fill_err;
    end
  end

  // held response under back-pressure
  a_resp_hold: assert property (
    @(posedge mcic_clk) disable iff (!cpurst_b)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_data) && $stable(resp_err));

endmodule

`default_nettype wire

// ==== rtl/mcic_line_cache.sv ====
`default_nettype none

module mcic_line_cache
  import mcic_pkg::*;
(
  input  wire            mcic_clk,
  input  wire            cpurst_b,
  input  wire            lookup_valid,
  input  wire mcic_pa_u  lookup_addr,
  input  wire            refill_valid,
  input  wire mcic_pa_u  refill_addr,
  input  wire  [127:0]   refill_line,
  output logic           lookup_done,
  output logic           lookup_hit,
  output logic [63:0]    lookup_data
);

  localparam int lines = 1 << mcic_index_w;

  // per-line state
  logic [lines-1:0]        valid_q;
  logic [mcic_tag_w-1:0]   tag_mem [lines];
  logic [127:0]            line_mem [lines];

  // read side
  logic [mcic_index_w-1:0] rd_idx;
  logic [127:0]            rd_line;
  logic                    rd_hit;

  // write side
  logic [mcic_index_w-1:0] wr_idx;

  // ==========================================================================
  // lookup
  // ==========================================================================
  assign rd_idx  = lookup_addr.cache.index;
  assign rd_line = line_mem[rd_idx];
  // tag compare only counts on a filled entry
  assign rd_hit  = valid_q[rd_idx] && (tag_mem[rd_idx] == lookup_addr.cache.tag);

  // result one cycle after the lookup pulse
  always_ff @(posedge mcic_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      lookup_done <= 1'b0;
      lookup_hit  <= 1'b0;
    end
    else
    begin
      lookup_done <= lookup_valid;
      lookup_hit  <= lookup_valid && rd_hit;
    end
  end

  // wanted dword of the line
  always_ff @(posedge mcic_clk)
  begin
    if (lookup_valid)
      lookup_data <= lookup_addr.cache.dw_sel ? rd_line[127:64] : rd_line[63:0];
  end

  // ==========================================================================
  // refill
  // ==========================================================================
  assign wr_idx = refill_addr.cache.index;

  // valid bits set by refill, never invalidated
  always_ff @(posedge mcic_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      valid_q <= '0;
    else if (refill_valid)
      valid_q[wr_idx] <= 1'b1;
  end

  // tag and line written together
  always_ff @(posedge mcic_clk)
  begin
    if (refill_valid)
    begin
      tag_mem[wr_idx]  <= refill_addr.cache.tag;
      line_mem[wr_idx] <= refill_line;
    end
  end

  // ==========================================================================
  // checks
  // ==========================================================================
  // fixed one-cycle latency seen by the controller
  a_done_follows: assert property (
    @(posedge mcic_clk) disable iff (!cpurst_b)
    lookup_valid |=> lookup_done);

endmodule

`default_nettype wire

// ==== rtl/mcic_pkg.sv ====
`default_nettype none

package mcic_pkg;

  // ==========================================================================
  // bus response codes
  // ==========================================================================
  // okay and exokay are the only success codes
  localparam logic [1:0] mcic_resp_okay   = 2'b00;
  localparam logic [1:0] mcic_resp_exokay = 2'b01;
  // slave side failure
  localparam logic [1:0] mcic_resp_slverr = 2'b10;
  // no slave at this address
  localparam logic [1:0] mcic_resp_decerr = 2'b11;

  // ==========================================================================
  // cache geometry
  // ==========================================================================
  // 64 lines of 16 bytes each
  localparam int mcic_index_w = 6;
  // pa[39:10]
  localparam int mcic_tag_w   = 30;

  // ==========================================================================
  // physical address, two decodes of the same 40 bits
  // ==========================================================================
  typedef union packed {
    // line cache view
    struct packed {
      logic [mcic_tag_w-1:0]   tag;
      logic [mcic_index_w-1:0] index;
      // selects the 64-bit half of the line
      logic                    dw_sel;
      logic [2:0]              byte_off;
    } cache;
    // bus view, line address plus offset in the line
    struct packed {
      logic [35:0] line_addr;
      logic [3:0]  line_off;
    } bus;
  } mcic_pa_u;

endpackage

`default_nettype wire

// ==== rtl/mcic_top.sv ====
`default_nettype none

module mcic_top
  import mcic_pkg::*;
#(
  parameter logic [4:0] AR_ID = 5'h0a
)
(
  input  wire           mcic_clk,
  input  wire           cpurst_b,
  // mmu request
  input  wire           req_valid,
  input  wire  [39:0]   req_addr,
  output wire           req_ready,
  // mmu response
  output wire           resp_valid,
  output wire  [63:0]   resp_data,
  output wire           resp_err,
  input  wire           resp_ready,
  // bus read address
  output wire           ar_valid,
  input  wire           ar_ready,
  output wire  [4:0]    ar_id,
  output wire  [39:0]   ar_addr,
  // bus read data, no back-pressure
  input  wire           r_valid,
  input  wire  [4:0]    r_id,
  input  wire  [127:0]  r_data,
  input  wire  [1:0]    r_resp,
  input  wire           r_ecc_err
);

  // controller to cache
  wire            lookup_valid;
  wire mcic_pa_u  lookup_addr;
  wire            lookup_done;
  wire            lookup_hit;
  wire [63:0]     lookup_data;

  // controller to bus engine
  wire            miss_valid;
  wire            miss_ready;
  wire mcic_pa_u  miss_addr;
  wire            fill_valid;
  wire            fill_ready;
  wire [63:0]     fill_data;
  wire            fill_err;

  // bus engine to cache
  wire            refill_valid;
  wire mcic_pa_u  refill_addr;
  wire [127:0]    refill_line;

  // ==========================================================================
  // controller
  // ==========================================================================
  mcic_ctrl u_ctrl (
    .mcic_clk     (mcic_clk),
    .cpurst_b     (cpurst_b),
    .req_valid    (req_valid),
    .req_addr     (req_addr),
    .req_ready    (req_ready),
    .resp_valid   (resp_valid),
    .resp_data    (resp_data),
    .resp_err     (resp_err),
    .resp_ready   (resp_ready),
    .lookup_valid (lookup_valid),
    .lookup_addr  (lookup_addr),
    .lookup_done  (lookup_done),
    .lookup_hit   (lookup_hit),
    .lookup_data  (lookup_data),
    .miss_valid   (miss_valid),
    .miss_addr    (miss_addr),
    .miss_ready   (miss_ready),
    .fill_valid   (fill_valid),
    .fill_ready   (fill_ready),
    .fill_data    (fill_data),
    .fill_err     (fill_err)
  );

  // ==========================================================================
  // line cache and bus engine, side by side
  // ==========================================================================
  mcic_line_cache u_line_cache (
    .mcic_clk     (mcic_clk),
    .cpurst_b     (cpurst_b),
    .lookup_valid (lookup_valid),
    .lookup_addr  (lookup_addr),
    .refill_valid (refill_valid),
    .refill_addr  (refill_addr),
    .refill_line  (refill_line),
    .lookup_done  (lookup_done),
    .lookup_hit   (lookup_hit),
    .lookup_data  (lookup_data)
  );

  mcic_bus_read #(
    .AR_ID (AR_ID)
  ) u_bus_read (
    .mcic_clk     (mcic_clk),
    .cpurst_b     (cpurst_b),
    .miss_valid   (miss_valid),
    .miss_addr    (miss_addr),
    .miss_ready   (miss_ready),
    .ar_valid     (ar_valid),
    .ar_ready     (ar_ready),
    .ar_id        (ar_id),
    .ar_addr      (ar_addr),
    .r_valid      (r_valid),
    .r_id         (r_id),
    .r_data       (r_data),
    .r_resp       (r_resp),
    .r_ecc_err    (r_ecc_err),
    .fill_valid   (fill_valid),
    .fill_ready   (fill_ready),
    .fill_data    (fill_data),
    .fill_err     (fill_err),
    .refill_valid (refill_valid),
    .refill_addr  (refill_addr),
    .refill_line  (refill_line)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the mcic testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module mcic_tb \
  --Mdir obj_dir -o mcic_sim \
  -f filelist.f

# the simulator exit code is not used, the log is searched instead
./obj_dir/mcic_sim 2>&1 | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// ==== test/mcic_mem_model.sv ====
`default_nettype none

module mcic_mem_model
  import mcic_pkg::*;
#(
  parameter logic [4:0]  bus_id   = 5'h0a,
  parameter logic [31:0] lcg_seed = 32'h0000_0001
)
(
  input  wire          mcic_clk,
  input  wire          ar_valid,
  output logic         ar_ready,
  input  wire  [39:0]  ar_addr,
  output logic         r_valid,
  output logic [4:0]   r_id,
  output logic [127:0] r_data,
  output logic [1:0]   r_resp,
  output logic         r_ecc_err
);

  logic [31:0] rnd;
  logic        busy;
  logic [39:0] line_addr;
  // stray beats still to send, then idle cycles before the real beat
  logic [1:0]  strays;
  logic [2:0]  delay;

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // memory contents, one dword per 8-aligned address
  function automatic logic [63:0] dword_at(input logic [39:0] a);
    return {24'd0, a[39:3], 3'b000} ^ 64'h5a5a_c3c3_0f0f_9696;
  endfunction

  initial
  begin
    rnd       = lcg_seed;
    busy      = 1'b0;
    line_addr = '0;
    strays    = 2'd0;
    delay     = 3'd0;
    ar_ready  = 1'b0;
    r_valid   = 1'b0;
    r_id      = '0;
    r_data    = '0;
    r_resp    = mcic_resp_okay;
    r_ecc_err = 1'b0;
  end

  // ==========================================================================
  // slave side, everything driven on the falling edge
  // ==========================================================================
  always @(negedge mcic_clk)
  begin
    rnd      = next_rand(rnd);
    r_valid  = 1'b0;
    // ready about three cycles in four
    ar_ready = (rnd[31:30] != 2'b00);
    if (busy && strays != 2'd0)
    begin
      // beat of some other id, odd xor keeps it different
      r_valid   = 1'b1;
      r_id      = bus_id ^ {rnd[22:19], 1'b1};
      r_data    = {4{rnd}};
      r_resp    = rnd[29:28];
      r_ecc_err = rnd[17];
      strays    = strays - 2'd1;
    end
    else if (busy && delay != 3'd0)
      delay = delay - 3'd1;
    else if (busy)
    begin
      // the real beat, lower dword at the line address
      r_valid   = 1'b1;
      r_id      = bus_id;
      r_data    = {dword_at(line_addr + 40'd8), dword_at(line_addr)};
      r_resp    = line_addr[39] ? mcic_resp_slverr :
                  (rnd[18] ? mcic_resp_exokay : mcic_resp_okay);
      r_ecc_err = !line_addr[39] && line_addr[38];
      busy      = 1'b0;
    end
    // handshake lands on the next rising edge
    if (ar_valid && ar_ready)
    begin
      line_addr = ar_addr;
      busy      = 1'b1;
      strays    = rnd[27:26];
      delay     = rnd[25:23];
    end
  end

endmodule

`default_nettype wire

// ==== test/mcic_tb.sv ====
`default_nettype none

module mcic_tb;

  localparam logic [4:0]  bus_id      = 5'h0a;
  localparam logic [31:0] seed        = 32'hd0af_f3a2;
  localparam int          n_req       = 300;
  localparam int          timeout_cyc = n_req * 40;
  localparam logic [63:0] data_mask   = 64'h5a5a_c3c3_0f0f_9696;

  logic         mcic_clk;
  logic         cpurst_b;
  logic         req_valid;
  logic [39:0]  req_addr;
  wire          req_ready;
  wire          resp_valid;
  wire  [63:0]  resp_data;
  wire          resp_err;
  logic         resp_ready;
  wire          ar_valid;
  wire          ar_ready;
  wire  [4:0]   ar_id;
  wire  [39:0]  ar_addr;
  wire          r_valid;
  wire  [4:0]   r_id;
  wire  [127:0] r_data;
  wire  [1:0]   r_resp;
  wire          r_ecc_err;

  // expectations for the request in flight
  logic [31:0]  rnd;
  logic [39:0]  cur_addr;
  logic [63:0]  exp_data;
  logic         exp_err;
  logic         exp_ecc;
  logic         exp_hit;
  // lines held cleanly, per cache index
  logic [35:0]  mirror_line [64];
  logic [63:0]  mirror_vld;
  int           acc_cnt;
  int           resp_cnt;
  int           ar_cnt;
  int           wait_cyc;
  int           cyc_cnt = 0;
  int           sent;

  mcic_top #(
    .AR_ID (bus_id)
  ) uut (
    .mcic_clk   (mcic_clk),
    .cpurst_b   (cpurst_b),
    .req_valid  (req_valid),
    .req_addr   (req_addr),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp_data  (resp_data),
    .resp_err   (resp_err),
    .resp_ready (resp_ready),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .ar_id      (ar_id),
    .ar_addr    (ar_addr),
    .r_valid    (r_valid),
    .r_id       (r_id),
    .r_data     (r_data),
    .r_resp     (r_resp),
    .r_ecc_err  (r_ecc_err)
  );

  mcic_mem_model #(
    .bus_id   (bus_id),
    .lcg_seed (seed)
  ) u_mem (
    .mcic_clk  (mcic_clk),
    .ar_valid  (ar_valid),
    .ar_ready  (ar_ready),
    .ar_addr   (ar_addr),
    .r_valid   (r_valid),
    .r_id      (r_id),
    .r_data    (r_data),
    .r_resp    (r_resp),
    .r_ecc_err (r_ecc_err)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  always #2 mcic_clk = ~mcic_clk;

  always @(posedge mcic_clk)
    cyc_cnt <= cyc_cnt + 1;

  // ==========================================================================
  // bookkeeping on the rising edge
  // ==========================================================================
  always @(posedge mcic_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      acc_cnt    <= 0;
      resp_cnt   <= 0;
      ar_cnt     <= 0;
      wait_cyc   <= 0;
      mirror_vld <= '0;
    end
    else
    begin
      wait_cyc <= wait_cyc + 1;
      if (ar_valid && ar_ready)
        ar_cnt <= ar_cnt + 1;
      if (req_valid && req_ready)
      begin
        acc_cnt  <= acc_cnt + 1;
        ar_cnt   <= 0;
        wait_cyc <= 0;
      end
      if (resp_valid && resp_ready)
      begin
        resp_cnt <= resp_cnt + 1;
        // clean miss leaves the line in the cache
        if (!exp_hit && !exp_err)
          mirror_vld[cur_addr[9:4]] <= 1'b1;
      end
    end
  end

  always @(posedge mcic_clk)
  begin
    if (cpurst_b && resp_valid && resp_ready && !exp_hit && !exp_err)
      mirror_line[cur_addr[9:4]] <= cur_addr[39:4];
  end

  // ==========================================================================
  // checks
  // ==========================================================================
  resp_value: assert property (@(posedge mcic_clk) disable iff (!cpurst_b)
    resp_valid && resp_ready && (!resp_err || exp_ecc) |-> resp_data == exp_data)
    else report_failure($sformatf("ERROR resp_data got %h exp %h",
                                  $sampled(resp_data), $sampled(exp_data)));

  resp_flag: assert property (@(posedge mcic_clk) disable iff (!cpurst_b)
    resp_valid && resp_ready |-> resp_err == exp_err)
    else report_failure($sformatf("ERROR resp_err got %h exp %h",
                                  $sampled(resp_err), $sampled(exp_err)));

  // cached lines answer in two cycles
  hit_latency: assert property (@(posedge mcic_clk) disable iff (!cpurst_b)
    $rose(resp_valid) && exp_hit |-> wait_cyc == 2)
    else report_failure($sformatf("ERROR hit latency got %h exp %h", $sampled(wait_cyc), 2));

  ar_count: assert property (@(posedge mcic_clk) disable iff (!cpurst_b)
    resp_valid && resp_ready |-> ar_cnt == (exp_hit ? 0 : 1))
    else report_failure($sformatf("ERROR ar handshakes got %h exp %h",
                                  $sampled(ar_cnt), $sampled(exp_hit) ? 0 : 1));

  ar_id_value: assert property (@(posedge mcic_clk) disable iff (!cpurst_b)
    ar_valid |-> ar_id == bus_id)
    else report_failure($sformatf("ERROR ar_id got %h exp %h", $sampled(ar_id), bus_id));

  // whole-line read of the requested address
  ar_addr_value: assert property (@(posedge mcic_clk) disable iff (!cpurst_b)
    ar_valid |-> ar_addr == {cur_addr[39:4], 4'h0})
    else report_failure($sformatf("ERROR ar_addr got %h exp %h",
                                  $sampled(ar_addr), {$sampled(cur_addr[39:4]), 4'h0}));

  resp_hold: assert property (@(posedge mcic_clk) disable iff (!cpurst_b)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_data) && $stable(resp_err))
    else report_failure("response changed while held by back-pressure");

  req_blocked: assert property (@(posedge mcic_clk) disable iff (!cpurst_b)
    resp_valid |-> !req_ready)
    else report_failure("req_ready went high before the response was taken");

  fill_to_resp: assert property (@(posedge mcic_clk) disable iff (!cpurst_b)
    $rose(uut.fill_valid) |=> $rose(resp_valid))
    else report_failure("response did not follow the fill by one cycle");

  // one answer per accepted request, nothing from stray beats
  resp_order: assert property (@(posedge mcic_clk) disable iff (!cpurst_b)
    resp_valid && resp_ready |-> resp_cnt + 1 == acc_cnt)
    else report_failure($sformatf("ERROR response count got %h exp %h",
                                  $sampled(resp_cnt) + 1, $sampled(acc_cnt)));

  initial
  begin
    wait (cyc_cnt >= timeout_cyc);
    report_failure("run did not finish before the cycle limit");
  end

  // ==========================================================================
  // stimulus on the falling edge
  // ==========================================================================
  initial
  begin
    logic [39:0] addr;
    mcic_clk   = 1'b0;
    cpurst_b   = 1'b0;
    req_valid  = 1'b0;
    req_addr   = '0;
    resp_ready = 1'b0;
    rnd        = seed;
    cur_addr   = '0;
    exp_data   = '0;
    exp_err    = 1'b0;
    exp_ecc    = 1'b0;
    exp_hit    = 1'b0;
    sent       = 0;
    repeat (10) @(negedge mcic_clk);
    reset_state: assert (!resp_valid && !ar_valid && req_ready && !uut.miss_valid &&
                         !uut.fill_valid && !uut.lookup_valid && !uut.refill_valid)
      else report_failure("outputs not in their idle state during reset");
    cpurst_b = 1'b1;
    while (resp_cnt < n_req)
    begin
      @(negedge mcic_clk);
      rnd = lcg_next(rnd);
      // back-pressure about one cycle in four
      resp_ready = (rnd[31:30] != 2'b00);
      if (req_valid)
        req_valid = 1'b0;
      else if (req_ready && sent < n_req && rnd[29])
      begin
        rnd = lcg_next(rnd);
        // repeat the last address now and then
        if (rnd[31:29] == 3'b000)
          addr = cur_addr;
        else
        begin
          // 256 lines over 64 indices
          addr = {2'b00, 26'h2a5_1c3, rnd[27:20], rnd[19], rnd[18:16]};
          if (rnd[15:12] == 4'h0)
            addr[39] = 1'b1;
          else if (rnd[15:12] == 4'h1)
            addr[38] = 1'b1;
        end
        cur_addr  = addr;
        exp_err   = addr[39] || addr[38];
        exp_ecc   = !addr[39] && addr[38];
        exp_data  = exp_ecc ? 64'd0 : ({24'd0, addr[39:3], 3'b000} ^ data_mask);
        exp_hit   = mirror_vld[addr[9:4]] && (mirror_line[addr[9:4]] == addr[39:4]);
        req_addr  = addr;
        req_valid = 1'b1;
        sent      = sent + 1;
      end
    end
    repeat (4) @(negedge mcic_clk);
    if (acc_cnt == n_req && resp_cnt == n_req && !resp_valid)
    begin
      $display("NO ERRORS");
      $finish;
    end
    else
      report_failure("request and response counts differ at the end of the run");
  end

endmodule

`default_nettype wire
